// ==== compile.f ====
isa_pkg.sv
ctrl_pkg.sv
decode_control.sv
reg_file_bypass.sv
hazard_detect.sv
operand_extend.sv
branch_resolve.sv
decode_stage.sv
tb_decode_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_decode_stage -o sim_decode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_decode)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage;
    import isa_pkg::*;
    import ctrl_pkg::*;

    // control-word fields compared against the model when not stalled
    localparam logic [31:0] FIELD_MASK = 32'hE000_0000 | (32'd7 << DST_REG_LO) |
                                         (32'd1 << DUMP) | (32'd1 << EXCEPTION) |
                                         (32'd1 << JUMP) | (32'd1 << BRANCH) |
                                         (32'd1 << SIGNED_EXT) | (32'd1 << MEM_WR) |
                                         (32'd1 << MEM_EN) | (32'd1 << REG_WRITE_EN) | 32'd3;

    logic        clk;
    logic        rst;
    logic [15:0] instr;
    logic [15:0] pc;
    logic [15:0] pc_plus_two;
    logic [15:0] writedata;
    logic [15:0] idex_instr;
    logic [15:0] memwb_instr;
    logic        idex_mem_en;
    logic        idex_mem_wr;
    logic        memwb_reg_write_en;
    reg_dst_e    memwb_reg_dst;
    logic [15:0] read1_data;
    logic [15:0] read2_data;
    logic [15:0] imm5_ext;
    logic [15:0] imm8_ext;
    logic [15:0] btr_out;
    logic [15:0] next_pc;
    logic [31:0] ctrl_word;
    logic        if_flush;
    logic        pc_write_en;
    logic        ifid_write_en;

    logic [15:0] regs_model [8];
    logic [15:0] lfsr_state = 16'd6;

    decode_stage u_dut (
        .clk                (clk),
        .rst                (rst),
        .instr              (instr),
        .pc                 (pc),
        .pc_plus_two        (pc_plus_two),
        .writedata          (writedata),
        .idex_instr         (idex_instr),
        .memwb_instr        (memwb_instr),
        .idex_mem_en        (idex_mem_en),
        .idex_mem_wr        (idex_mem_wr),
        .memwb_reg_write_en (memwb_reg_write_en),
        .memwb_reg_dst      (memwb_reg_dst),
        .read1_data         (read1_data),
        .read2_data         (read2_data),
        .imm5_ext           (imm5_ext),
        .imm8_ext           (imm8_ext),
        .btr_out            (btr_out),
        .next_pc            (next_pc),
        .ctrl_word          (ctrl_word),
        .if_flush           (if_flush),
        .pc_write_en        (pc_write_en),
        .ifid_write_en      (ifid_write_en)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[14:0], fb};
        end
        return v;
    endfunction

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    function automatic logic [2:0] dst_number(input reg_dst_e dst, input logic [15:0] ins);
        if (dst == dst_rt) return ins[7:5];
        if (dst == dst_rs) return ins[10:8];
        if (dst == dst_r7) return 3'd7;
        return ins[4:2];
    endfunction

    // expected values of the checked control-word fields
    function automatic logic [31:0] model_ctrl(input logic [15:0] ins);
        opcode_e     op;
        reg_dst_e    dst;
        logic        wr;
        logic [31:0] w;
        op = opcode_e'(ins[15:11]);
        dst = dst_rd;
        wr = 1'b0;
        w = '0;
        case (op)
            op_halt: w[DUMP] = 1'b1;
            op_nop, op_beqz, op_bnez, op_bltz, op_bgez, op_j, op_jr: ;
            op_addi, op_subi, op_xori, op_andni, op_ld: begin
                dst = dst_rt;
                wr = 1'b1;
            end
            op_st: dst = dst_rt;
            op_stu, op_lbi, op_slbi: begin
                dst = dst_rs;
                wr = 1'b1;
            end
            op_btr, op_alu_rr: wr = 1'b1;
            op_jal, op_jalr: begin
                dst = dst_r7;
                wr = 1'b1;
            end
            default: w[EXCEPTION] = 1'b1;
        endcase
        w[REG_DST_HI:REG_DST_LO] = dst;
        w[DST_REG_HI:DST_REG_LO] = dst_number(dst, ins);
        w[REG_WRITE_EN] = wr;
        w[MEM_EN] = op inside {op_st, op_ld, op_stu};
        w[MEM_WR] = op inside {op_st, op_stu};
        w[BRANCH] = op inside {op_beqz, op_bnez, op_bltz, op_bgez};
        w[JUMP] = op inside {op_j, op_jr, op_jal, op_jalr};
        w[SIGNED_EXT] = op inside {op_addi, op_subi, op_st, op_ld, op_stu, op_beqz, op_bnez,
                                   op_bltz, op_bgez, op_lbi, op_j, op_jr, op_jal, op_jalr};
        return w;
    endfunction

    task automatic check_outputs();
        opcode_e     op;
        logic [2:0]  wsel;
        logic [15:0] rs_val;
        logic [15:0] rt_val;
        logic [15:0] imm5;
        logic [15:0] imm8;
        logic [15:0] imm11;
        logic [15:0] rev;
        logic [15:0] exp_npc;
        logic [31:0] exp_word;
        logic        stall;
        logic        taken;
        logic        sx;
        @(negedge clk);
        op = opcode_e'(instr[15:11]);
        wsel = dst_number(memwb_reg_dst, memwb_instr);
        rs_val = (memwb_reg_write_en && wsel == instr[10:8]) ? writedata : regs_model[instr[10:8]];
        rt_val = (memwb_reg_write_en && wsel == instr[7:5]) ? writedata : regs_model[instr[7:5]];
        stall = idex_mem_en && !idex_mem_wr &&
                (idex_instr[7:5] == instr[10:8] ||
                 (op inside {op_alu_rr, op_st, op_stu} && idex_instr[7:5] == instr[7:5]));
        exp_word = model_ctrl(instr);
        sx = exp_word[SIGNED_EXT];
        imm5 = sx ? 16'($signed(instr[4:0])) : 16'(instr[4:0]);
        imm8 = sx ? 16'($signed(instr[7:0])) : 16'(instr[7:0]);
        imm11 = 16'($signed(instr[10:0]));
        rev = {<<{rs_val}};
        compare_value("read1_data", 32'(read1_data), 32'(rs_val));
        compare_value("read2_data", 32'(read2_data), 32'(rt_val));
        compare_value("pc_write_en", 32'(pc_write_en), 32'(!stall));
        compare_value("ifid_write_en", 32'(ifid_write_en), 32'(!stall));
        if (stall) begin
            compare_value("ctrl_word", ctrl_word, 32'd0);
        end else begin
            compare_value("ctrl_word", ctrl_word & FIELD_MASK, exp_word);
        end
        compare_value("imm5_ext", 32'(imm5_ext), 32'(imm5));
        compare_value("imm8_ext", 32'(imm8_ext), 32'(imm8));
        compare_value("btr_out", 32'(btr_out), 32'(rev));
        // a bubble never redirects
        exp_npc = pc_plus_two;
        taken = 1'b0;
        if (!stall) begin
            case (op)
                op_beqz: taken = (rs_val == 16'd0);
                op_bnez: taken = (rs_val != 16'd0);
                op_bltz: taken = rs_val[15];
                op_bgez: taken = !rs_val[15];
                default: ;
            endcase
            if (taken) exp_npc = pc_plus_two + imm8;
            if (op inside {op_j, op_jal}) exp_npc = pc_plus_two + imm11;
            if (op inside {op_jr, op_jalr}) exp_npc = rs_val + imm8;
        end
        compare_value("next_pc", 32'(next_pc), 32'(exp_npc));
        compare_value("if_flush", 32'(if_flush),
                      32'(!stall && (taken || op inside {op_j, op_jal, op_jr, op_jalr})));
        // write commits on the coming rising edge
        if (memwb_reg_write_en) regs_model[wsel] = writedata;
    endtask

    task automatic drive_random();
        logic [15:0] ins;
        logic [15:0] idex;
        logic [15:0] wd;
        logic [15:0] ppt;
        ins = rand_bits(16);
        idex = rand_bits(16);
        // steer the ID/EX destination onto rs or rt half of the time
        case (rand_bits(2))
            16'd0: idex[7:5] = ins[10:8];
            16'd1: idex[7:5] = ins[7:5];
            default: ;
        endcase
        wd = rand_bits(16);
        if (rand_bits(2) == 16'd0) wd = '0;
        ppt = rand_bits(16);
        instr <= ins;
        idex_instr <= idex;
        writedata <= wd;
        pc_plus_two <= ppt;
        pc <= ppt - 16'd2;
        memwb_instr <= rand_bits(16);
        memwb_reg_write_en <= (rand_bits(1) != 16'd0);
        memwb_reg_dst <= reg_dst_e'(2'(rand_bits(2)));
        idex_mem_en <= (rand_bits(1) != 16'd0);
        idex_mem_wr <= (rand_bits(2) == 16'd0);
    endtask

    task automatic wait_fetch_enabled();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(pc_write_en && ifid_write_en && !if_flush)) begin
            if (cycles == 20) begin
                $display("fetch enables did not come up within 20 cycles after reset");
                stop_on_failure();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    initial begin
        rst = 1'b1;
        instr = {op_nop, 11'd0};
        pc = '0;
        pc_plus_two = 16'd2;
        writedata = '0;
        idex_instr = '0;
        memwb_instr = '0;
        idex_mem_en = 1'b0;
        idex_mem_wr = 1'b0;
        memwb_reg_write_en = 1'b0;
        memwb_reg_dst = dst_rd;
        for (int i = 0; i < 8; i++) begin
            regs_model[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        wait_fetch_enabled();
        // every register reads zero after reset
        for (int r = 0; r < 8; r++) begin
            @(posedge clk);
            instr <= {op_nop, 3'(r), 3'(r + 1), 5'd0};
            check_outputs();
        end
        for (int n = 0; n < 800; n++) begin
            @(posedge clk);
            drive_random();
            check_outputs();
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [isa_pkg::INSTR_W-1:0]  instr,
    input  logic [isa_pkg::DATA_W-1:0]   pc,
    input  logic [isa_pkg::DATA_W-1:0]   pc_plus_two,
    input  logic [isa_pkg::DATA_W-1:0]   writedata,
    input  logic [isa_pkg::INSTR_W-1:0]  idex_instr,
    input  logic [isa_pkg::INSTR_W-1:0]  memwb_instr,
    input  logic                         idex_mem_en,
    input  logic                         idex_mem_wr,
    input  logic                         memwb_reg_write_en,
    input  ctrl_pkg::reg_dst_e           memwb_reg_dst,
    output logic [isa_pkg::DATA_W-1:0]   read1_data,
    output logic [isa_pkg::DATA_W-1:0]   read2_data,
    output logic [isa_pkg::DATA_W-1:0]   imm5_ext,
    output logic [isa_pkg::DATA_W-1:0]   imm8_ext,
    output logic [isa_pkg::DATA_W-1:0]   btr_out,
    output logic [isa_pkg::DATA_W-1:0]   next_pc,
    output logic [ctrl_pkg::CTRL_W-1:0]  ctrl_word,
    output logic                         if_flush,
    output logic                         pc_write_en,
    output logic                         ifid_write_en
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    opcode_e           opcode;
    logic [CTRL_W-1:0] ctrl_raw;
    logic [CTRL_W-1:0] dec_word;
    logic [DATA_W-1:0] imm11_ext;
    logic [2:0]        write_sel;
    logic              ctrl_sel;

    // register number named by a reg_dst choice
    function automatic logic [2:0] reg_field(input reg_dst_e dst,
                                             input logic [INSTR_W-1:0] ins);
        case (dst)
            dst_rd:  return ins[RD_HI:RD_LO];
            dst_rt:  return ins[RT_HI:RT_LO];
            dst_rs:  return ins[RS_HI:RS_LO];
            default: return 3'd7;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[OPC_HI:OPC_LO]);

    decode_control u_control (
        .opcode (opcode),
        .func   (instr[FUNC_HI:FUNC_LO]),
        .ctrl   (ctrl_raw)
    );

    always_comb begin
        dec_word = ctrl_raw;
        dec_word[DST_REG_HI:DST_REG_LO] =
            reg_field(reg_dst_e'(ctrl_raw[REG_DST_HI:REG_DST_LO]), instr);
    end

    // bubble on a load-use stall
    assign ctrl_word = ctrl_sel ? dec_word : '0;
    assign write_sel = reg_field(memwb_reg_dst, memwb_instr);

    reg_file_bypass u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .read1_sel  (instr[RS_HI:RS_LO]),
        .read2_sel  (instr[RT_HI:RT_LO]),
        .write_sel  (write_sel),
        .writedata  (writedata),
        .write      (memwb_reg_write_en),
        .read1_data (read1_data),
        .read2_data (read2_data)
    );

    hazard_detect u_hazard (
        .ifid_instr    (instr),
        .idex_instr    (idex_instr),
        .idex_mem_en   (idex_mem_en),
        .idex_mem_wr   (idex_mem_wr),
        .pc_write_en   (pc_write_en),
        .ifid_write_en (ifid_write_en),
        .ctrl_sel      (ctrl_sel)
    );

    // extension follows the opcode even while stalled
    operand_extend u_extend (
        .instr      (instr),
        .signed_ext (dec_word[SIGNED_EXT]),
        .rs_data    (read1_data),
        .imm5_ext   (imm5_ext),
        .imm8_ext   (imm8_ext),
        .imm11_ext  (imm11_ext),
        .btr_out    (btr_out)
    );

    // gated word, a stalled branch must not redirect
    branch_resolve u_branch (
        .rs_data     (read1_data),
        .pc_plus_two (pc_plus_two),
        .imm8_ext    (imm8_ext),
        .imm11_ext   (imm11_ext),
        .cond        (instr[OPC_LO+1:OPC_LO]),
        .branch      (ctrl_word[BRANCH]),
        .jump        (ctrl_word[JUMP]),
        .next_pc     (next_pc),
        .if_flush    (if_flush)
    );

    // fetch must hand over a known pc whenever it advances
    pc_known: assert property (
        @(posedge clk) disable iff (rst) pc_write_en |-> !$isunknown({pc, pc_plus_two})
    ) else $error("unknown pc from fetch");

endmodule

// ==== branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve (
    input  logic [isa_pkg::DATA_W-1:0] rs_data,
    input  logic [isa_pkg::DATA_W-1:0] pc_plus_two,
    input  logic [isa_pkg::DATA_W-1:0] imm8_ext,
    input  logic [isa_pkg::DATA_W-1:0] imm11_ext,
    input  logic [1:0]                 cond,
    input  logic                       branch,
    input  logic                       jump,
    output logic [isa_pkg::DATA_W-1:0] next_pc,
    output logic                       if_flush
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic              taken;
    logic [DATA_W-1:0] rs_target;
    logic [DATA_W-1:0] br_target;
    logic [DATA_W-1:0] jmp_target;
    pc_src_e           pc_src;

    // beqz, bnez, bltz, bgez in opcode order
    always_comb begin
        case (cond)
            2'b00:   taken = (rs_data == '0);
            2'b01:   taken = (rs_data != '0);
            2'b10:   taken = rs_data[DATA_W-1];
            default: taken = !rs_data[DATA_W-1];
        endcase
    end

    assign rs_target  = rs_data + imm8_ext;
    assign br_target  = pc_plus_two + imm8_ext;
    assign jmp_target = pc_plus_two + imm11_ext;

    always_comb begin
        if (jump) begin
            // jr and jalr have the low opcode bit set
            pc_src = cond[0] ? npc_rs_imm8 : npc_pc_imm11;
        end else if (branch && taken) begin
            pc_src = npc_pc_imm8;
        end else begin
            pc_src = npc_seq;
        end
    end

    always_comb begin
        case (pc_src)
            npc_rs_imm8:  next_pc = rs_target;
            npc_pc_imm8:  next_pc = br_target;
            npc_pc_imm11: next_pc = jmp_target;
            default:      next_pc = pc_plus_two;
        endcase
    end

    // any redirect kills the instruction fetched behind us
    assign if_flush = (pc_src != npc_seq);

endmodule

// ==== operand_extend.sv ====
`timescale 1ns/1ps

module operand_extend (
    input  logic [isa_pkg::INSTR_W-1:0] instr,
    input  logic                        signed_ext,
    input  logic [isa_pkg::DATA_W-1:0]  rs_data,
    output logic [isa_pkg::DATA_W-1:0]  imm5_ext,
    output logic [isa_pkg::DATA_W-1:0]  imm8_ext,
    output logic [isa_pkg::DATA_W-1:0]  imm11_ext,
    output logic [isa_pkg::DATA_W-1:0]  btr_out
);
    import isa_pkg::*;

    // fill bit is the field msb, or zero for unsigned
    assign imm5_ext  = {{(DATA_W-5){signed_ext & instr[4]}}, instr[4:0]};
    assign imm8_ext  = {{(DATA_W-8){signed_ext & instr[7]}}, instr[7:0]};
    assign imm11_ext = {{(DATA_W-11){signed_ext & instr[10]}}, instr[10:0]};

    // btr result, rs with bit order reversed
    always_comb begin
        for (int i = 0; i < DATA_W; i++) begin
            btr_out[i] = rs_data[DATA_W-1-i];
        end
    end

endmodule

// ==== hazard_detect.sv ====
`timescale 1ns/1ps

module hazard_detect (
    input  logic [isa_pkg::INSTR_W-1:0] ifid_instr,
    input  logic [isa_pkg::INSTR_W-1:0] idex_instr,
    input  logic                        idex_mem_en,
    input  logic                        idex_mem_wr,
    output logic                        pc_write_en,
    output logic                        ifid_write_en,
    output logic                        ctrl_sel
);
    import isa_pkg::*;

    opcode_e    opcode;
    logic [2:0] load_dst;
    logic       load_in_ex;
    logic       reads_rt;
    logic       stall;

    assign opcode     = opcode_e'(ifid_instr[OPC_HI:OPC_LO]);
    assign load_in_ex = idex_mem_en && !idex_mem_wr;
    // loads write their rt field
    assign load_dst   = idex_instr[RT_HI:RT_LO];
    assign reads_rt   = opcode inside {op_alu_rr, op_st, op_stu};

    assign stall = load_in_ex &&
                   (load_dst == ifid_instr[RS_HI:RS_LO] ||
                    (reads_rt && load_dst == ifid_instr[RT_HI:RT_LO]));

    // hold fetch and insert a bubble
    assign pc_write_en   = !stall;
    assign ifid_write_en = !stall;
    assign ctrl_sel      = !stall;

    always_comb begin
        assert (pc_write_en == ifid_write_en)
            else $error("pc and IF/ID enables disagree");
    end

endmodule

// ==== reg_file_bypass.sv ====
`timescale 1ns/1ps

module reg_file_bypass (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [2:0]                  read1_sel,
    input  logic [2:0]                  read2_sel,
    input  logic [2:0]                  write_sel,
    input  logic [isa_pkg::DATA_W-1:0]  writedata,
    input  logic                        write,
    output logic [isa_pkg::DATA_W-1:0]  read1_data,
    output logic [isa_pkg::DATA_W-1:0]  read2_data
);
    import isa_pkg::*;

    logic [DATA_W-1:0] regs [REG_N];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[write_sel] <= writedata;
        end
    end

    // writeback in the same cycle wins over the stored copy
    assign read1_data = (write && read1_sel == write_sel) ? writedata : regs[read1_sel];
    assign read2_data = (write && read2_sel == write_sel) ? writedata : regs[read2_sel];

    // an X here would reach both read ports through the bypass
    writedata_known: assert property (
        @(posedge clk) disable iff (rst) write |-> !$isunknown(writedata)
    ) else $error("register write of unknown data to r%0d", write_sel);

endmodule

// ==== decode_control.sv ====
`timescale 1ns/1ps

module decode_control (
    input  isa_pkg::opcode_e             opcode,
    input  logic [1:0]                   func,
    output logic [ctrl_pkg::CTRL_W-1:0]  ctrl
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    reg_dst_e dst;
    reg_src_e wd_src;
    alu_src_e src1;
    alu_src_e src2;
    alu_op_e  op;
    logic     reg_wr;
    logic     cin;
    logic     inv_a;
    logic     inv_b;
    logic     sgn;
    logic     dump;
    logic     exc;

    always_comb begin
        dst    = dst_rd;
        wd_src = wd_alu;
        src1   = sel_rs;
        src2   = sel_rt;
        op     = alu_add;
        reg_wr = 1'b0;
        cin    = 1'b0;
        inv_a  = 1'b0;
        inv_b  = 1'b0;
        sgn    = 1'b0;
        dump   = 1'b0;
        exc    = 1'b0;
        case (opcode)
            op_halt: dump = 1'b1;
            // targets are formed in this stage, ALU idle
            op_nop, op_beqz, op_bnez, op_bltz, op_bgez, op_j, op_jr: ;
            op_addi, op_subi: begin
                dst    = dst_rt;
                src2   = sel_imm5;
                reg_wr = 1'b1;
                sgn    = 1'b1;
                // subi is imm - rs
                inv_a  = (opcode == op_subi);
                cin    = (opcode == op_subi);
            end
            op_xori, op_andni: begin
                dst    = dst_rt;
                src2   = sel_imm5;
                reg_wr = 1'b1;
                op     = (opcode == op_xori) ? alu_xor : alu_and;
                inv_b  = (opcode == op_andni);
            end
            op_st, op_ld, op_stu: begin
                // effective address rs + imm5
                src2   = sel_imm5;
                sgn    = 1'b1;
                dst    = (opcode == op_stu) ? dst_rs : dst_rt;
                wd_src = (opcode == op_ld) ? wd_mem : wd_alu;
                reg_wr = (opcode != op_st);
            end
            op_btr: begin
                wd_src = wd_btr;
                reg_wr = 1'b1;
            end
            op_alu_rr: begin
                reg_wr = 1'b1;
                case (func_e'(func))
                    fn_add: sgn = 1'b1;
                    fn_sub: begin
                        // rt - rs
                        inv_a = 1'b1;
                        cin   = 1'b1;
                        sgn   = 1'b1;
                    end
                    fn_xor: op = alu_xor;
                    fn_andn: begin
                        op    = alu_and;
                        inv_b = 1'b1;
                    end
                endcase
            end
            op_lbi: begin
                dst    = dst_rs;
                wd_src = wd_imm8;
                reg_wr = 1'b1;
            end
            op_slbi: begin
                dst    = dst_rs;
                src1   = sel_rs_hi;
                src2   = sel_imm8;
                op     = alu_or;
                reg_wr = 1'b1;
            end
            op_jal, op_jalr: begin
                dst    = dst_r7;
                wd_src = wd_pc_plus_two;
                reg_wr = 1'b1;
            end
            default: exc = 1'b1;
        endcase
    end

    assign ctrl[REG_DST_HI:REG_DST_LO]   = dst;
    assign ctrl[REG_SRC_HI:REG_SRC_LO]   = wd_src;
    assign ctrl[ALU_SRC1_HI:ALU_SRC1_LO] = src1;
    assign ctrl[ALU_SRC2_HI:ALU_SRC2_LO] = src2;
    assign ctrl[REG_WRITE_EN]            = reg_wr;
    assign ctrl[MEM_EN]                  = opcode inside {op_st, op_ld, op_stu};
    assign ctrl[MEM_WR]                  = opcode inside {op_st, op_stu};
    // only the logical immediates zero extend
    assign ctrl[SIGNED_EXT] = opcode inside {op_addi, op_subi, op_st, op_ld, op_stu,
                                             op_beqz, op_bnez, op_bltz, op_bgez, op_lbi,
                                             op_j, op_jr, op_jal, op_jalr};
    assign ctrl[BRANCH]                  = opcode inside {op_beqz, op_bnez, op_bltz, op_bgez};
    assign ctrl[JUMP]                    = opcode inside {op_j, op_jr, op_jal, op_jalr};
    assign ctrl[EXCEPTION]               = exc;
    assign ctrl[ALU_OP_HI:ALU_OP_LO]     = op;
    assign ctrl[CIN]                     = cin;
    assign ctrl[INV_A]                   = inv_a;
    assign ctrl[INV_B]                   = inv_b;
    assign ctrl[SIGN]                    = sgn;
    assign ctrl[DUMP]                    = dump;
    // reserved bits, plus dst_reg which the top level fills from the instruction
    assign ctrl[CTRL_W-1:DST_REG_LO]     = '0;

    // branch and jump would fight over next_pc in branch_resolve
    always_comb begin
        assert (!(ctrl[BRANCH] && ctrl[JUMP]))
            else $error("opcode %0h decodes as both branch and jump", opcode);
    end

endmodule

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

    localparam int CTRL_W = 32;

    // control word layout
    localparam int REG_DST_HI   = 1;
    localparam int REG_DST_LO   = 0;
    localparam int REG_SRC_HI   = 4;
    localparam int REG_SRC_LO   = 2;
    localparam int ALU_SRC1_HI  = 7;
    localparam int ALU_SRC1_LO  = 5;
    localparam int ALU_SRC2_HI  = 10;
    localparam int ALU_SRC2_LO  = 8;
    localparam int REG_WRITE_EN = 11;
    localparam int MEM_EN       = 12;
    localparam int MEM_WR       = 13;
    localparam int SIGNED_EXT   = 14;
    localparam int BRANCH       = 15;
    localparam int JUMP         = 16;
    localparam int EXCEPTION    = 17;
    localparam int ALU_OP_HI    = 20;
    localparam int ALU_OP_LO    = 18;
    localparam int CIN          = 21;
    localparam int INV_A        = 22;
    localparam int INV_B        = 23;
    localparam int SIGN         = 24;
    localparam int DUMP         = 25;
    localparam int DST_REG_HI   = 28;
    localparam int DST_REG_LO   = 26;

    typedef enum logic [1:0] {dst_rd, dst_rt, dst_rs, dst_r7} reg_dst_e;
    typedef enum logic [2:0] {wd_alu, wd_mem, wd_imm8, wd_pc_plus_two, wd_btr} reg_src_e;
    // rs_hi is rs shifted up by eight, for slbi
    typedef enum logic [2:0] {sel_rs, sel_rt, sel_imm5, sel_imm8, sel_rs_hi} alu_src_e;
    typedef enum logic [2:0] {
        alu_rol, alu_sll, alu_ror, alu_srl, alu_add, alu_or, alu_xor, alu_and
    } alu_op_e;
    typedef enum logic [2:0] {npc_seq, npc_rs_imm8, npc_pc_imm8, npc_pc_imm11} pc_src_e;

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

    localparam int DATA_W  = 16;
    localparam int INSTR_W = 16;
    localparam int REG_N   = 8;

    // instruction fields
    localparam int OPC_HI  = 15;
    localparam int OPC_LO  = 11;
    localparam int RS_HI   = 10;
    localparam int RS_LO   = 8;
    localparam int RT_HI   = 7;
    localparam int RT_LO   = 5;
    localparam int RD_HI   = 4;
    localparam int RD_LO   = 2;
    localparam int FUNC_HI = 1;
    localparam int FUNC_LO = 0;

    // major opcodes, bits 15:11
    typedef enum logic [4:0] {
        op_halt   = 5'b00000,
        op_nop    = 5'b00001,
        op_j      = 5'b00100,
        op_jr     = 5'b00101,
        op_jal    = 5'b00110,
        op_jalr   = 5'b00111,
        op_addi   = 5'b01000,
        op_subi   = 5'b01001,
        op_xori   = 5'b01010,
        op_andni  = 5'b01011,
        op_beqz   = 5'b01100,
        op_bnez   = 5'b01101,
        op_bltz   = 5'b01110,
        op_bgez   = 5'b01111,
        op_st     = 5'b10000,
        op_ld     = 5'b10001,
        op_slbi   = 5'b10010,
        op_stu    = 5'b10011,
        op_lbi    = 5'b11000,
        op_btr    = 5'b11001,
        op_alu_rr = 5'b11011
    } opcode_e;

    // register-register function code, bits 1:0
    typedef enum logic [1:0] {fn_add, fn_sub, fn_xor, fn_andn} func_e;

endpackage
